// ==== rtl/sat_size_pkg.sv ====
package sat_size_pkg;

    // one clause bin
    localparam int NUM_VARS = 8;
    localparam int NUM_CLAUSES = 4;

    // entry i holds level i+1
    localparam int NUM_LVLS = 8;

    // level 0 is the root
    localparam int WIDTH_LVL = 4;
    localparam int WIDTH_BIN_ID = 8;

endpackage

// ==== rtl/sat_state_pkg.sv ====
package sat_state_pkg;

    localparam int WIDTH_VAL = 2;

    // top value bit means assigned
    localparam logic [1:0] VAL_UNASSIGNED = 2'b00;
    localparam logic [1:0] VAL_FALSE = 2'b10;
    localparam logic [1:0] VAL_TRUE = 2'b11;

    // literal encoding per variable per clause
    localparam logic [1:0] LIT_ABSENT = 2'b00;
    localparam logic [1:0] LIT_NEG = 2'b10;
    localparam logic [1:0] LIT_POS = 2'b11;

    // var state word holds value over level over clause 3..0 membership
    localparam int WIDTH_VAR_STATE =
        WIDTH_VAL + sat_size_pkg::WIDTH_LVL + 2 * sat_size_pkg::NUM_CLAUSES;
    localparam int VS_MEMBER_LSB = 0;
    localparam int VS_LVL_LSB = 2 * sat_size_pkg::NUM_CLAUSES;
    localparam int VS_VALUE_LSB = VS_LVL_LSB + sat_size_pkg::WIDTH_LVL;

    // lvl state word is a valid flag over the bin id
    localparam int WIDTH_LVL_STATE = 1 + sat_size_pkg::WIDTH_BIN_ID;

    // conflict analysis FSM
    localparam logic [2:0] ANALYZE_IDLE = 3'd0;
    localparam logic [2:0] FIND_LEARNTC = 3'd1;
    localparam logic [2:0] ADD_LEARNTC = 3'd2;
    localparam logic [2:0] ANALYZE_DONE = 3'd3;
    localparam logic [2:0] ANALYZE_WAIT = 3'd4;

endpackage

// ==== rtl/decision_unit.sv ====
module decision_unit (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   load_lvl_en_i,
    input  logic [sat_size_pkg::WIDTH_LVL-1:0]     load_lvl_i,
    input  logic                                   start_decision_i,
    input  logic [sat_size_pkg::NUM_VARS*2-1:0]    var_value_i,
    input  logic                                   apply_bkt_i,
    input  logic [sat_size_pkg::WIDTH_LVL-1:0]     bkt_lvl_i,
    output logic [sat_size_pkg::NUM_VARS-1:0]      decided_o,
    output logic                                   done_decision_o,
    output logic [sat_size_pkg::WIDTH_LVL-1:0]     cur_lvl_o
);

    logic [sat_size_pkg::NUM_VARS-1:0] pick;
    logic any_free;

    // lowest unassigned variable wins
    always_comb begin
        pick = '0;
        any_free = 1'b0;
        for (int v = 0; v < sat_size_pkg::NUM_VARS; v++) begin
            if (!any_free && var_value_i[2*v +: 2] == sat_state_pkg::VAL_UNASSIGNED) begin
                pick[v] = 1'b1;
                any_free = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            decided_o <= '0;
            done_decision_o <= 1'b0;
            cur_lvl_o <= '0;
        end else begin
            decided_o <= start_decision_i ? pick : '0;
            done_decision_o <= start_decision_i;
            if (load_lvl_en_i) begin
                cur_lvl_o <= load_lvl_i;
            end else if (apply_bkt_i) begin
                cur_lvl_o <= bkt_lvl_i;
            end else if (start_decision_i && any_free) begin
                // new level opens with the decision
                cur_lvl_o <= cur_lvl_o + 1'b1;
            end
        end
    end

    // every new level needs a level entry
    assert property (@(posedge clk) disable iff (!rst)
        start_decision_i && any_free |-> cur_lvl_o < sat_size_pkg::NUM_LVLS);

endmodule

// ==== rtl/var_state_bank.sv ====
module var_state_bank (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [sat_size_pkg::NUM_VARS-1:0]     wr_states_i,
    input  logic [sat_size_pkg::NUM_VARS*sat_state_pkg::WIDTH_VAR_STATE-1:0] var_states_i,
    input  logic [sat_size_pkg::NUM_VARS-1:0]     decided_i,
    input  logic [sat_size_pkg::WIDTH_LVL-1:0]    cur_lvl_i,
    input  logic                                  apply_imply_i,
    input  logic                                  apply_bkt_i,
    input  logic [sat_size_pkg::WIDTH_LVL-1:0]    bkt_lvl_i,
    output logic [sat_size_pkg::NUM_VARS*sat_state_pkg::WIDTH_VAR_STATE-1:0] var_states_o,
    output logic [sat_size_pkg::NUM_VARS*2-1:0]   var_value_o,
    output logic [sat_size_pkg::NUM_VARS*sat_size_pkg::WIDTH_LVL-1:0] var_lvl_o,
    output logic [sat_size_pkg::NUM_VARS-1:0]     find_imply_o,
    output logic [sat_size_pkg::NUM_CLAUSES-1:0]  find_conflict_o,
    output logic [sat_size_pkg::NUM_VARS*2-1:0]   learnt_lit_o,
    output logic [sat_size_pkg::WIDTH_LVL-1:0]    max_lvl_o
);

    logic [sat_state_pkg::WIDTH_VAR_STATE-1:0] vs_r [sat_size_pkg::NUM_VARS];
    logic [1:0] val [sat_size_pkg::NUM_VARS];
    logic [sat_size_pkg::WIDTH_LVL-1:0] lvl [sat_size_pkg::NUM_VARS];
    logic [1:0] lit [sat_size_pkg::NUM_CLAUSES][sat_size_pkg::NUM_VARS];
    logic [sat_size_pkg::NUM_VARS-1:0] lit_true [sat_size_pkg::NUM_CLAUSES];
    logic [sat_size_pkg::NUM_VARS-1:0] lit_free [sat_size_pkg::NUM_CLAUSES];
    logic [sat_size_pkg::NUM_VARS-1:0] lit_any [sat_size_pkg::NUM_CLAUSES];
    logic [sat_size_pkg::NUM_CLAUSES-1:0] unit;
    logic [sat_size_pkg::NUM_VARS-1:0] imply_pol;
    logic [sat_size_pkg::NUM_VARS-1:0] lvl_above;
    logic found;

    // field split and flat outputs
    always_comb begin
        for (int v = 0; v < sat_size_pkg::NUM_VARS; v++) begin
            val[v] = vs_r[v][sat_state_pkg::VS_VALUE_LSB +: sat_state_pkg::WIDTH_VAL];
            lvl[v] = vs_r[v][sat_state_pkg::VS_LVL_LSB +: sat_size_pkg::WIDTH_LVL];
            var_states_o[v*sat_state_pkg::WIDTH_VAR_STATE +: sat_state_pkg::WIDTH_VAR_STATE] =
                vs_r[v];
            var_value_o[2*v +: 2] = val[v];
            var_lvl_o[v*sat_size_pkg::WIDTH_LVL +: sat_size_pkg::WIDTH_LVL] = lvl[v];
            lvl_above[v] = val[v][1] && (lvl[v] > cur_lvl_i);
            for (int c = 0; c < sat_size_pkg::NUM_CLAUSES; c++) begin
                lit[c][v] = vs_r[v][sat_state_pkg::VS_MEMBER_LSB + 2*c +: 2];
            end
        end
    end

    // clause evaluation
    always_comb begin
        for (int c = 0; c < sat_size_pkg::NUM_CLAUSES; c++) begin
            for (int v = 0; v < sat_size_pkg::NUM_VARS; v++) begin
                lit_any[c][v] = lit[c][v] != sat_state_pkg::LIT_ABSENT;
                lit_free[c][v] = lit_any[c][v] && val[v] == sat_state_pkg::VAL_UNASSIGNED;
                lit_true[c][v] = lit_any[c][v] && val[v][1] && val[v][0] == lit[c][v][0];
            end
            unit[c] = $onehot(lit_free[c]) && lit_true[c] == '0;
            find_conflict_o[c] = lit_any[c] != '0 && lit_true[c] == '0 && lit_free[c] == '0;
        end
    end

    // lowest unit clause sets the implied polarity
    always_comb begin
        find_imply_o = '0;
        imply_pol = '0;
        for (int c = sat_size_pkg::NUM_CLAUSES - 1; c >= 0; c--) begin
            for (int v = 0; v < sat_size_pkg::NUM_VARS; v++) begin
                if (unit[c] && lit_free[c][v]) begin
                    find_imply_o[v] = 1'b1;
                    imply_pol[v] = lit[c][v][0];
                end
            end
        end
    end

    // first conflicting clause gives the learnt literals and max level
    always_comb begin
        found = 1'b0;
        learnt_lit_o = '0;
        max_lvl_o = '0;
        for (int c = 0; c < sat_size_pkg::NUM_CLAUSES; c++) begin
            if (find_conflict_o[c] && !found) begin
                found = 1'b1;
                for (int v = 0; v < sat_size_pkg::NUM_VARS; v++) begin
                    learnt_lit_o[2*v +: 2] = lit[c][v];
                    if (lit_any[c][v] && lvl[v] < cur_lvl_i && lvl[v] > max_lvl_o) begin
                        max_lvl_o = lvl[v];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int v = 0; v < sat_size_pkg::NUM_VARS; v++) begin
                vs_r[v] <= '0;
            end
        end else begin
            for (int v = 0; v < sat_size_pkg::NUM_VARS; v++) begin
                if (wr_states_i[v]) begin
                    vs_r[v] <= var_states_i[v*sat_state_pkg::WIDTH_VAR_STATE +:
                                            sat_state_pkg::WIDTH_VAR_STATE];
                end else if (apply_bkt_i && lvl[v] > bkt_lvl_i) begin
                    vs_r[v][sat_state_pkg::VS_VALUE_LSB +: sat_state_pkg::WIDTH_VAL] <=
                        sat_state_pkg::VAL_UNASSIGNED;
                    vs_r[v][sat_state_pkg::VS_LVL_LSB +: sat_size_pkg::WIDTH_LVL] <= '0;
                end else if (decided_i[v]) begin
                    vs_r[v][sat_state_pkg::VS_VALUE_LSB +: sat_state_pkg::WIDTH_VAL] <=
                        sat_state_pkg::VAL_TRUE;
                    vs_r[v][sat_state_pkg::VS_LVL_LSB +: sat_size_pkg::WIDTH_LVL] <= cur_lvl_i;
                end else if (apply_imply_i && find_imply_o[v]) begin
                    vs_r[v][sat_state_pkg::VS_VALUE_LSB +: sat_state_pkg::WIDTH_VAL] <=
                        {1'b1, imply_pol[v]};
                    vs_r[v][sat_state_pkg::VS_LVL_LSB +: sat_size_pkg::WIDTH_LVL] <= cur_lvl_i;
                end
            end
        end
    end

    // decision unit's level never trails an assignment during implication
    assert property (@(posedge clk) disable iff (!rst) apply_imply_i |-> lvl_above == '0);

endmodule

// ==== rtl/lvl_state_bank.sv ====
module lvl_state_bank (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [sat_size_pkg::NUM_LVLS-1:0]         wr_states_i,
    input  logic [sat_size_pkg::NUM_LVLS*sat_state_pkg::WIDTH_LVL_STATE-1:0] lvl_states_i,
    input  logic                                      decision_valid_i,
    input  logic [sat_size_pkg::WIDTH_BIN_ID-1:0]     cur_bin_num_i,
    input  logic [sat_size_pkg::WIDTH_LVL-1:0]        cur_lvl_i,
    input  logic [sat_size_pkg::WIDTH_LVL-1:0]        max_lvl_i,
    input  logic                                      apply_bkt_i,
    input  logic [sat_size_pkg::WIDTH_LVL-1:0]        bkt_lvl_i,
    output logic [sat_size_pkg::NUM_LVLS*sat_state_pkg::WIDTH_LVL_STATE-1:0] lvl_states_o,
    output logic [sat_size_pkg::WIDTH_BIN_ID-1:0]     bkt_bin_o,
    output logic [sat_size_pkg::WIDTH_LVL-1:0]        bkt_lvl_o
);

    localparam int VALID_BIT = sat_state_pkg::WIDTH_LVL_STATE - 1;

    logic [sat_state_pkg::WIDTH_LVL_STATE-1:0] ls_r [sat_size_pkg::NUM_LVLS];
    logic found;

    // bin at max level, then the lowest level opened by that bin
    always_comb begin
        bkt_bin_o = '0;
        bkt_lvl_o = max_lvl_i;
        found = 1'b0;
        for (int i = 0; i < sat_size_pkg::NUM_LVLS; i++) begin
            lvl_states_o[i*sat_state_pkg::WIDTH_LVL_STATE +: sat_state_pkg::WIDTH_LVL_STATE] =
                ls_r[i];
            if (max_lvl_i == sat_size_pkg::WIDTH_LVL'(i + 1)) begin
                bkt_bin_o = ls_r[i][sat_size_pkg::WIDTH_BIN_ID-1:0];
            end
        end
        for (int i = 0; i < sat_size_pkg::NUM_LVLS; i++) begin
            if (!found && max_lvl_i != '0 && ls_r[i][VALID_BIT] &&
                ls_r[i][sat_size_pkg::WIDTH_BIN_ID-1:0] == bkt_bin_o) begin
                found = 1'b1;
                // one below the bin's first level
                bkt_lvl_o = sat_size_pkg::WIDTH_LVL'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < sat_size_pkg::NUM_LVLS; i++) begin
                ls_r[i] <= '0;
            end
        end else begin
            for (int i = 0; i < sat_size_pkg::NUM_LVLS; i++) begin
                if (wr_states_i[i]) begin
                    ls_r[i] <= lvl_states_i[i*sat_state_pkg::WIDTH_LVL_STATE +:
                                            sat_state_pkg::WIDTH_LVL_STATE];
                end else if (apply_bkt_i && sat_size_pkg::WIDTH_LVL'(i + 1) > bkt_lvl_i) begin
                    ls_r[i] <= '0;
                end else if (decision_valid_i && cur_lvl_i == sat_size_pkg::WIDTH_LVL'(i + 1)) begin
                    ls_r[i] <= {1'b1, cur_bin_num_i};
                end
            end
        end
    end

endmodule

// ==== rtl/state_list.sv ====
module state_list (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [sat_size_pkg::NUM_VARS-1:0]     wr_var_states_i,
    input  logic [sat_size_pkg::NUM_VARS*sat_state_pkg::WIDTH_VAR_STATE-1:0] var_states_i,
    input  logic [sat_size_pkg::NUM_LVLS-1:0]     wr_lvl_states_i,
    input  logic [sat_size_pkg::NUM_LVLS*sat_state_pkg::WIDTH_LVL_STATE-1:0] lvl_states_i,
    input  logic                                  base_lvl_en_i,
    input  logic [sat_size_pkg::WIDTH_LVL-1:0]    base_lvl_i,
    input  logic                                  load_lvl_en_i,
    input  logic [sat_size_pkg::WIDTH_LVL-1:0]    load_lvl_i,
    input  logic                                  start_decision_i,
    input  logic [sat_size_pkg::WIDTH_BIN_ID-1:0] cur_bin_num_i,
    input  logic                                  apply_imply_i,
    input  logic                                  apply_analyze_i,
    input  logic                                  apply_bkt_cur_bin_i,
    output logic [sat_size_pkg::NUM_VARS*sat_state_pkg::WIDTH_VAR_STATE-1:0] var_states_o,
    output logic [sat_size_pkg::NUM_VARS*2-1:0]   var_value_o,
    output logic [sat_size_pkg::NUM_VARS*sat_size_pkg::WIDTH_LVL-1:0] var_lvl_o,
    output logic [sat_size_pkg::NUM_LVLS*sat_state_pkg::WIDTH_LVL_STATE-1:0] lvl_states_o,
    output logic [sat_size_pkg::NUM_VARS*2-1:0]   learnt_lit_o,
    output logic [sat_size_pkg::WIDTH_LVL-1:0]    cur_lvl_o,
    output logic                                  done_decision_o,
    output logic                                  done_imply_o,
    output logic                                  find_conflict_o,
    output logic                                  add_learntc_en_o,
    output logic                                  done_analyze_o,
    output logic [sat_size_pkg::WIDTH_BIN_ID-1:0] bkt_bin_o,
    output logic [sat_size_pkg::WIDTH_LVL-1:0]    bkt_lvl_o,
    output logic                                  done_bkt_cur_bin_o
);

    logic [sat_size_pkg::NUM_VARS-1:0] decided;
    logic [sat_size_pkg::NUM_VARS-1:0] find_imply;
    logic [sat_size_pkg::NUM_VARS-1:0] find_imply_pre;
    logic [sat_size_pkg::NUM_CLAUSES-1:0] find_conflict;
    logic [sat_size_pkg::NUM_CLAUSES-1:0] find_conflict_pre;
    logic [sat_size_pkg::WIDTH_LVL-1:0] max_lvl;
    logic [sat_size_pkg::WIDTH_LVL-1:0] base_lvl_r;
    logic [sat_size_pkg::WIDTH_LVL-1:0] bkt_lvl_ls;
    logic [sat_size_pkg::WIDTH_LVL-1:0] bkt_lvl_sel;
    logic [sat_size_pkg::WIDTH_BIN_ID-1:0] bkt_bin_ls;
    logic [2:0] state_r;
    logic [2:0] state_nxt;

    decision_unit u_decision_unit (
        .clk              (clk),
        .rst              (rst),
        .load_lvl_en_i    (load_lvl_en_i),
        .load_lvl_i       (load_lvl_i),
        .start_decision_i (start_decision_i),
        .var_value_i      (var_value_o),
        .apply_bkt_i      (apply_bkt_cur_bin_i),
        .bkt_lvl_i        (bkt_lvl_o),
        .decided_o        (decided),
        .done_decision_o  (done_decision_o),
        .cur_lvl_o        (cur_lvl_o)
    );

    var_state_bank u_var_state_bank (
        .clk             (clk),
        .rst             (rst),
        .wr_states_i     (wr_var_states_i),
        .var_states_i    (var_states_i),
        .decided_i       (decided),
        .cur_lvl_i       (cur_lvl_o),
        .apply_imply_i   (apply_imply_i),
        .apply_bkt_i     (apply_bkt_cur_bin_i),
        .bkt_lvl_i       (bkt_lvl_o),
        .var_states_o    (var_states_o),
        .var_value_o     (var_value_o),
        .var_lvl_o       (var_lvl_o),
        .find_imply_o    (find_imply),
        .find_conflict_o (find_conflict),
        .learnt_lit_o    (learnt_lit_o),
        .max_lvl_o       (max_lvl)
    );

    lvl_state_bank u_lvl_state_bank (
        .clk              (clk),
        .rst              (rst),
        .wr_states_i      (wr_lvl_states_i),
        .lvl_states_i     (lvl_states_i),
        .decision_valid_i (|decided),
        .cur_bin_num_i    (cur_bin_num_i),
        .cur_lvl_i        (cur_lvl_o),
        .max_lvl_i        (max_lvl),
        .apply_bkt_i      (apply_bkt_cur_bin_i),
        .bkt_lvl_i        (bkt_lvl_o),
        .lvl_states_o     (lvl_states_o),
        .bkt_bin_o        (bkt_bin_ls),
        .bkt_lvl_o        (bkt_lvl_ls)
    );

    assign find_conflict_o = |find_conflict;
    assign done_bkt_cur_bin_o = apply_bkt_cur_bin_i;

    // below the base level the whole bin is dropped
    assign bkt_lvl_sel = (max_lvl >= base_lvl_r) ? max_lvl : bkt_lvl_ls;

    always_comb begin
        case (state_r)
            sat_state_pkg::ANALYZE_IDLE:
                state_nxt = apply_analyze_i ? sat_state_pkg::FIND_LEARNTC : state_r;
            sat_state_pkg::FIND_LEARNTC:
                state_nxt = (find_conflict == find_conflict_pre) ?
                            sat_state_pkg::ADD_LEARNTC : state_r;
            sat_state_pkg::ADD_LEARNTC:
                state_nxt = sat_state_pkg::ANALYZE_DONE;
            sat_state_pkg::ANALYZE_DONE:
                state_nxt = sat_state_pkg::ANALYZE_WAIT;
            sat_state_pkg::ANALYZE_WAIT:
                // controller drops apply when it is through
                state_nxt = apply_analyze_i ? state_r : sat_state_pkg::ANALYZE_IDLE;
            default:
                state_nxt = sat_state_pkg::ANALYZE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_r <= sat_state_pkg::ANALYZE_IDLE;
            base_lvl_r <= '0;
            find_imply_pre <= '0;
            find_conflict_pre <= '0;
            done_imply_o <= 1'b0;
            add_learntc_en_o <= 1'b0;
            done_analyze_o <= 1'b0;
            bkt_bin_o <= '0;
            bkt_lvl_o <= '0;
        end else begin
            state_r <= state_nxt;
            find_imply_pre <= find_imply;
            find_conflict_pre <= find_conflict;
            if (base_lvl_en_i) begin
                base_lvl_r <= base_lvl_i;
            end
            // fixpoint or conflict ends implication
            done_imply_o <= apply_imply_i && (find_imply == find_imply_pre || find_conflict_o);
            add_learntc_en_o <= state_r == sat_state_pkg::ADD_LEARNTC;
            done_analyze_o <= state_r == sat_state_pkg::ANALYZE_DONE;
            if (state_r == sat_state_pkg::ANALYZE_DONE) begin
                bkt_bin_o <= bkt_bin_ls;
                bkt_lvl_o <= bkt_lvl_sel;
            end
        end
    end

    // a learnt clause needs a live conflict
    assert property (@(posedge clk) disable iff (!rst) add_learntc_en_o |-> find_conflict_o);

endmodule

// ==== verification/state_list_tb.sv ====
module state_list_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk;
    logic rst;
    logic [sat_size_pkg::NUM_VARS-1:0] wr_var_states_i;
    logic [sat_size_pkg::NUM_VARS*sat_state_pkg::WIDTH_VAR_STATE-1:0] var_states_i;
    logic [sat_size_pkg::NUM_LVLS-1:0] wr_lvl_states_i;
    logic [sat_size_pkg::NUM_LVLS*sat_state_pkg::WIDTH_LVL_STATE-1:0] lvl_states_i;
    logic base_lvl_en_i;
    logic [sat_size_pkg::WIDTH_LVL-1:0] base_lvl_i;
    logic load_lvl_en_i;
    logic [sat_size_pkg::WIDTH_LVL-1:0] load_lvl_i;
    logic start_decision_i;
    logic [sat_size_pkg::WIDTH_BIN_ID-1:0] cur_bin_num_i;
    logic apply_imply_i;
    logic apply_analyze_i;
    logic apply_bkt_cur_bin_i;
    logic [sat_size_pkg::NUM_VARS*sat_state_pkg::WIDTH_VAR_STATE-1:0] var_states_o;
    logic [sat_size_pkg::NUM_VARS*2-1:0] var_value_o;
    logic [sat_size_pkg::NUM_VARS*sat_size_pkg::WIDTH_LVL-1:0] var_lvl_o;
    logic [sat_size_pkg::NUM_LVLS*sat_state_pkg::WIDTH_LVL_STATE-1:0] lvl_states_o;
    logic [sat_size_pkg::NUM_VARS*2-1:0] learnt_lit_o;
    logic [sat_size_pkg::WIDTH_LVL-1:0] cur_lvl_o;
    logic done_decision_o;
    logic done_imply_o;
    logic find_conflict_o;
    logic add_learntc_en_o;
    logic done_analyze_o;
    logic [sat_size_pkg::WIDTH_BIN_ID-1:0] bkt_bin_o;
    logic [sat_size_pkg::WIDTH_LVL-1:0] bkt_lvl_o;
    logic done_bkt_cur_bin_o;

    int value_errors = 0;
    int missing_done = 0;
    int case_errors = 0;
    int num_cases = 0;
    bit cases_ready = 1'b0;
    // level the case file expects the DUT to be at
    logic [31:0] exp_cur_lvl = 0;

    state_list u_state_list (.*);

    always #4 clk = ~clk;

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        value_errors++;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic check_reset();
        @(negedge clk);
        if ({done_decision_o, done_imply_o, add_learntc_en_o, done_analyze_o} !== 4'b0)
            report_mismatch("done flags after reset", 32'(done_decision_o), 32'h0);
        if (32'(cur_lvl_o) !== 32'h0)
            report_mismatch("cur_lvl_o after reset", 32'(cur_lvl_o), 32'h0);
        if (var_states_o !== '0 || lvl_states_o !== '0)
            report_mismatch("state buses after reset", 32'(var_states_o), 32'h0);
        if (32'(bkt_lvl_o) !== 32'h0 || 32'(bkt_bin_o) !== 32'h0)
            report_mismatch("bkt_bin_o after reset", 32'(bkt_bin_o), 32'h0);
        if (find_conflict_o !== 1'b0 || done_bkt_cur_bin_o !== 1'b0)
            report_mismatch("find_conflict_o after reset", 32'(find_conflict_o), 32'h0);
    endtask

    task automatic load_var(input int idx, input logic [31:0] word);
        @(negedge clk);
        wr_var_states_i = '0;
        wr_var_states_i[idx] = 1'b1;
        var_states_i[idx*sat_state_pkg::WIDTH_VAR_STATE +: sat_state_pkg::WIDTH_VAR_STATE] =
            word[sat_state_pkg::WIDTH_VAR_STATE-1:0];
        @(negedge clk);
        wr_var_states_i = '0;
    endtask

    task automatic load_lvl(input int idx, input logic [31:0] word);
        @(negedge clk);
        wr_lvl_states_i = '0;
        wr_lvl_states_i[idx] = 1'b1;
        lvl_states_i[idx*sat_state_pkg::WIDTH_LVL_STATE +: sat_state_pkg::WIDTH_LVL_STATE] =
            word[sat_state_pkg::WIDTH_LVL_STATE-1:0];
        @(negedge clk);
        wr_lvl_states_i = '0;
    endtask

    task automatic set_base(input logic [31:0] lvl);
        @(negedge clk);
        base_lvl_en_i = 1'b1;
        base_lvl_i = lvl[sat_size_pkg::WIDTH_LVL-1:0];
        @(negedge clk);
        base_lvl_en_i = 1'b0;
    endtask

    task automatic run_decision(input logic [31:0] bin, input int exp_var,
                                input logic [31:0] exp_lvl);
        logic [sat_state_pkg::WIDTH_VAR_STATE-1:0] word;
        int entry;
        @(negedge clk);
        start_decision_i = 1'b1;
        cur_bin_num_i = bin[sat_size_pkg::WIDTH_BIN_ID-1:0];
        @(negedge clk);
        start_decision_i = 1'b0;
        if (done_decision_o !== 1'b1)
            report_mismatch("done_decision_o one cycle after start", 32'(done_decision_o), 1);
        if (32'(cur_lvl_o) !== exp_lvl)
            report_mismatch("cur_lvl_o during done_decision_o", 32'(cur_lvl_o), exp_lvl);
        exp_cur_lvl = exp_lvl;
        @(negedge clk);
        if (done_decision_o !== 1'b0)
            report_mismatch("done_decision_o second cycle", 32'(done_decision_o), 0);
        if (exp_var < sat_size_pkg::NUM_VARS) begin
            word = var_states_o[exp_var*sat_state_pkg::WIDTH_VAR_STATE +:
                                sat_state_pkg::WIDTH_VAR_STATE];
            if (word[sat_state_pkg::VS_VALUE_LSB +: 2] !== sat_state_pkg::VAL_TRUE)
                report_mismatch("decided value", 32'(word), 32'(sat_state_pkg::VAL_TRUE));
            if (32'(word[sat_state_pkg::VS_LVL_LSB +: sat_size_pkg::WIDTH_LVL]) !== exp_lvl)
                report_mismatch("decided level", 32'(word), exp_lvl);
            entry = int'(exp_lvl) - 1;
            if (32'(lvl_states_o[entry*sat_state_pkg::WIDTH_LVL_STATE +:
                                 sat_state_pkg::WIDTH_LVL_STATE]) !== (32'h100 | bin))
                report_mismatch("level entry of new level", 32'(lvl_states_o), 32'h100 | bin);
        end
        idle(2);
    endtask

    task automatic run_imply(input logic [31:0] exp_vals, input logic [31:0] exp_conf);
        logic [sat_size_pkg::NUM_VARS*2-1:0] prev;
        int cycles;
        prev = var_value_o;
        @(negedge clk);
        apply_imply_i = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (done_imply_o !== 1'b1 && cycles < 64) begin
            @(negedge clk);
            cycles++;
        end
        apply_imply_i = 1'b0;
        if (done_imply_o !== 1'b1) begin
            $display("done_imply_o never arrived within 64 cycles of apply_imply_i");
            missing_done++;
        end else begin
            if (32'(var_value_o) !== exp_vals)
                report_mismatch("var_value_o after implication", 32'(var_value_o), exp_vals);
            if (32'(find_conflict_o) !== exp_conf)
                report_mismatch("find_conflict_o", 32'(find_conflict_o), exp_conf);
            // newly assigned variables belong to the current level
            for (int v = 0; v < sat_size_pkg::NUM_VARS; v++) begin
                if (!prev[2*v+1] && var_value_o[2*v+1] &&
                    32'(var_lvl_o[v*sat_size_pkg::WIDTH_LVL +: sat_size_pkg::WIDTH_LVL]) !==
                    exp_cur_lvl)
                    report_mismatch("implied level",
                                    32'(var_lvl_o[v*sat_size_pkg::WIDTH_LVL +:
                                                  sat_size_pkg::WIDTH_LVL]),
                                    exp_cur_lvl);
            end
        end
        idle(2);
    endtask

    task automatic run_analyze(input logic [31:0] exp_lit, input logic [31:0] exp_lvl,
                               input logic [31:0] exp_bin);
        int cycles;
        @(negedge clk);
        if (find_conflict_o !== 1'b1)
            report_mismatch("find_conflict_o before analysis", 32'(find_conflict_o), 1);
        apply_analyze_i = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (add_learntc_en_o !== 1'b1 && cycles < 64) begin
            @(negedge clk);
            cycles++;
        end
        if (add_learntc_en_o !== 1'b1) begin
            $display("add_learntc_en_o never arrived within 64 cycles of apply_analyze_i");
            missing_done++;
        end else begin
            // a stable conflict adds on the third edge from the sample
            if (cycles != 2)
                report_mismatch("add_learntc_en_o latency", 32'(cycles + 1), 3);
            @(negedge clk);
            if (done_analyze_o !== 1'b1 || add_learntc_en_o !== 1'b0)
                report_mismatch("done_analyze_o after add", 32'(done_analyze_o), 1);
            if (32'(learnt_lit_o) !== exp_lit)
                report_mismatch("learnt_lit_o", 32'(learnt_lit_o), exp_lit);
            if (32'(bkt_lvl_o) !== exp_lvl)
                report_mismatch("bkt_lvl_o", 32'(bkt_lvl_o), exp_lvl);
            if (32'(bkt_bin_o) !== exp_bin)
                report_mismatch("bkt_bin_o", 32'(bkt_bin_o), exp_bin);
        end
        apply_analyze_i = 1'b0;
        idle(2);
    endtask

    task automatic run_backtrack(input logic [31:0] exp_lvl);
        @(negedge clk);
        apply_bkt_cur_bin_i = 1'b1;
        #1;
        if (done_bkt_cur_bin_o !== 1'b1)
            report_mismatch("done_bkt_cur_bin_o", 32'(done_bkt_cur_bin_o), 1);
        @(negedge clk);
        apply_bkt_cur_bin_i = 1'b0;
        if (32'(cur_lvl_o) !== exp_lvl || cur_lvl_o !== bkt_lvl_o)
            report_mismatch("cur_lvl_o after backtrack", 32'(cur_lvl_o), exp_lvl);
        exp_cur_lvl = exp_lvl;
        for (int v = 0; v < sat_size_pkg::NUM_VARS; v++) begin
            if (32'(var_lvl_o[v*sat_size_pkg::WIDTH_LVL +: sat_size_pkg::WIDTH_LVL]) > exp_lvl)
                report_mismatch("variable level above backtrack", 32'(v), exp_lvl);
        end
        for (int i = 0; i < sat_size_pkg::NUM_LVLS; i++) begin
            if (i + 1 > int'(exp_lvl) && lvl_states_o[i*sat_state_pkg::WIDTH_LVL_STATE +:
                                                       sat_state_pkg::WIDTH_LVL_STATE] !== '0)
                report_mismatch("level entry above backtrack", 32'(i), 0);
        end
        idle(2);
    endtask

    task automatic check_state(input logic [31:0] kind, input int idx, input logic [31:0] exp);
        logic [31:0] got;
        case (kind)
            0: got = 32'(var_states_o[idx*sat_state_pkg::WIDTH_VAR_STATE +:
                                      sat_state_pkg::WIDTH_VAR_STATE]);
            1: got = 32'(lvl_states_o[idx*sat_state_pkg::WIDTH_LVL_STATE +:
                                      sat_state_pkg::WIDTH_LVL_STATE]);
            2: got = 32'(var_value_o);
            default: got = 32'(cur_lvl_o);
        endcase
        if (got !== exp)
            report_mismatch($sformatf("state kind %0d index %0d", kind, idx), got, exp);
    endtask

    // watchdog sized by the number of cases
    initial begin
        wait (cases_ready);
        #((16 + num_cases * 70) * 8);
        $display("timeout: the run did not finish in its time limit");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int fd;
        string line;
        string lines[$];
        string op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        clk = 1'b0;
        rst = 1'b0;
        wr_var_states_i = '0;
        var_states_i = '0;
        wr_lvl_states_i = '0;
        lvl_states_i = '0;
        base_lvl_en_i = 1'b0;
        base_lvl_i = '0;
        load_lvl_en_i = 1'b0;
        load_lvl_i = '0;
        start_decision_i = 1'b0;
        cur_bin_num_i = '0;
        apply_imply_i = 1'b0;
        apply_analyze_i = 1'b0;
        apply_bkt_cur_bin_i = 1'b0;
        fd = $fopen("verification/state_list_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            case_errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#")
                    lines.push_back(line);
            end
            $fclose(fd);
        end
        num_cases = lines.size();
        cases_ready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        check_reset();
        foreach (lines[i]) begin
            a = 0;
            b = 0;
            c = 0;
            if ($sscanf(lines[i], "%s %h %h %h", op, a, b, c) < 1)
                op = "";
            if (op == "LOAD_VAR") load_var(int'(a), b);
            else if (op == "LOAD_LVL") load_lvl(int'(a), b);
            else if (op == "BASE") set_base(a);
            else if (op == "DECIDE") run_decision(a, int'(b), c);
            else if (op == "IMPLY") run_imply(a, b);
            else if (op == "ANALYZE") run_analyze(a, b, c);
            else if (op == "BKT") run_backtrack(a);
            else if (op == "CHECK") check_state(a, int'(b), c);
            else begin
                $display("unknown command in case file line %0d", i);
                case_errors++;
            end
        end
        $display("%0d cases: %0d value errors, %0d missing done, %0d case file errors",
                 num_cases, value_errors, missing_done, case_errors);
        if (value_errors == 0 && missing_done == 0 && case_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== verification/state_list_cases.txt ====
# opcode arg_a arg_b arg_c, all hex; LOAD_VAR var word, LOAD_LVL entry word, BASE lvl
# DECIDE bin exp_var exp_lvl, IMPLY values conflict, ANALYZE learnt bkt_lvl bkt_bin, BKT lvl
# CHECK kind(0 var word, 1 lvl entry, 2 values, 3 cur_lvl) index expected
LOAD_VAR 0 0002 0
LOAD_VAR 1 000B 0
LOAD_VAR 2 008C 0
LOAD_VAR 3 00A0 0
LOAD_VAR 4 00E0 0
CHECK 0 2 008C
LOAD_LVL 7 01AB 0
CHECK 1 7 01AB
BASE 0 0 0
DECIDE 05 0 1
CHECK 0 0 3102
IMPLY 000F 0 0
IMPLY 003F 0 0
IMPLY 003F 0 0
CHECK 0 2 318C
DECIDE 09 3 2
IMPLY 02FF 1 0
ANALYZE 03A0 1 05
BKT 1 0 0
CHECK 0 4 00E0
CHECK 1 0 0105
CHECK 2 0 003F
LOAD_VAR 0 3100 0
LOAD_VAR 1 3100 0
LOAD_VAR 2 3100 0
LOAD_VAR 3 0002 0
LOAD_VAR 4 0002 0
LOAD_VAR 5 0002 0
BASE 4 0 0
DECIDE 07 3 2
DECIDE 07 4 3
DECIDE 0A 5 4
CHECK 2 0 0FFF
ANALYZE 0A80 1 07
BKT 1 0 0
CHECK 0 5 0002
CHECK 2 0 003F
LOAD_VAR 3 3100 0
LOAD_VAR 4 3100 0
LOAD_VAR 5 3100 0
LOAD_VAR 6 3100 0
LOAD_VAR 7 3100 0
DECIDE 0B FF 1
CHECK 3 0 0001

// ==== sat_state_list.f ====
rtl/sat_size_pkg.sv
rtl/sat_state_pkg.sv
rtl/decision_unit.sv
rtl/var_state_bank.sv
rtl/lvl_state_bank.sv
rtl/state_list.sv
verification/state_list_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the state_list testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module state_list_tb \
    -f sat_state_list.f -o state_list_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/state_list_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== PASS ===" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
